/* logic/mem_noc_pkg.sv */
package mem_noc_pkg;

  // number of independent memory columns
  localparam int NUM_COLS = 2;

  localparam int FLIT_DATA_W = 32; // payload bits carried by one flit

  // one flit on a network link
  typedef struct packed
  {
    logic                   last; // marks the final flit of a message
    logic [FLIT_DATA_W-1:0] data;
  } noc_flit_s;

  // valid and flit travel toward the receiver and ready comes back on its own wire
  typedef struct packed
  {
    logic      valid;
    noc_flit_s flit;
  } noc_link_s;

endpackage

/* logic/mem_msg_pkg.sv */
package mem_msg_pkg;

  localparam int ADDR_W = 28;
  localparam int DATA_W = 64; // one block is two flits wide

  // a column stalls issue once this many commands wait for DRAM
  localparam int MAX_OUTSTANDING = 2;
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  // index of the flit that closes a write command
  localparam int WR_LAST_IDX = 2;

  localparam int HDR_PAD_W = 2; // unused bits between opcode and address

  typedef enum logic [1:0]
  {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } mem_opcode_e;

  // whole memory message as seen on the DRAM ports
  typedef struct packed
  {
    mem_opcode_e         opcode;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
  } mem_msg_s;

  // layout of the header flit payload for commands and responses
  typedef struct packed
  {
    mem_opcode_e          opcode;
    logic [HDR_PAD_W-1:0] pad;
    logic [ADDR_W-1:0]    addr;
  } mem_hdr_s;

  typedef enum logic
  {
    e_run   = 1'b0,
    e_stall = 1'b1
  } ctrl_state_e;

endpackage

/* logic/cmd_link_deser.sv */
`timescale 1ns/1ps

module cmd_link_deser
  import mem_noc_pkg::*;
  import mem_msg_pkg::*;
  (
    input  logic      clk_i,
    input  logic      rst_i,
    input  noc_link_s link_i,
    output logic      ready_o,
    output mem_msg_s  msg_o,
    output logic      buf_full_o,
    input  logic      taken_i
  );

  logic [1:0] idx_r;
  logic       full_r;
  logic       full_n;
  logic       ready_r;
  logic       accept;
  mem_msg_s   msg_r;
  mem_hdr_s   hdr;

  assign accept = link_i.valid & ready_r;
  assign hdr    = mem_hdr_s'(link_i.flit.data); // only meaningful at index 0

  always_comb
  begin
    full_n = full_r;
    if (accept && link_i.flit.last)
    begin
      full_n = 1'b1;
    end
    else if (taken_i)
    begin
      full_n = 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      idx_r   <= '0;
      full_r  <= 1'b0;
      ready_r <= 1'b0;
    end
    else
    begin
      full_r  <= full_n;
      ready_r <= ~full_n; // reopens the cycle after the buffer is taken
      if (accept)
      begin
        idx_r <= link_i.flit.last ? 2'd0 : idx_r + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      case (idx_r)
        2'd0:
        begin
          msg_r.opcode <= hdr.opcode;
          msg_r.addr   <= hdr.addr;
          msg_r.data   <= '0; // reads go out with zero data
        end
        2'd1:    msg_r.data[FLIT_DATA_W-1:0]      <= link_i.flit.data;
        default: msg_r.data[DATA_W-1:FLIT_DATA_W] <= link_i.flit.data;
      endcase
    end
  end

  assign ready_o    = ready_r;
  assign buf_full_o = full_r;
  assign msg_o      = msg_r;

  // a read is one flit and a write is exactly three
  assert property (@(posedge clk_i) disable iff (rst_i)
    (accept && link_i.flit.last) |->
      ((idx_r == 2'd0) && (hdr.opcode == e_mem_rd)) ||
      ((idx_r == 2'(WR_LAST_IDX)) && (msg_r.opcode == e_mem_wr)))
    else $error("last flit at wrong position for opcode");

endmodule

/* logic/resp_link_ser.sv */
`timescale 1ns/1ps

module resp_link_ser
  import mem_noc_pkg::*;
  import mem_msg_pkg::*;
  (
    input  logic      clk_i,
    input  logic      rst_i,
    input  mem_msg_s  msg_i,
    input  logic      load_i,
    output logic      ready_o,
    output noc_link_s link_o,
    input  logic      link_ready_i
  );

  typedef enum logic [1:0]
  {
    e_idle,
    e_hdr,
    e_lo,
    e_hi
  } ser_state_e;

  ser_state_e state_r;
  mem_msg_s   msg_r;
  mem_hdr_s   hdr;

  assign ready_o = (state_r == e_idle);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r <= e_idle;
    end
    else
    begin
      case (state_r)
        e_idle:
        begin
          if (load_i)
          begin
            state_r <= e_hdr;
          end
        end
        e_hdr:
        begin
          if (link_ready_i)
          begin
            state_r <= (msg_r.opcode == e_mem_wr) ? e_idle : e_lo; // write ack is one flit
          end
        end
        e_lo:
        begin
          if (link_ready_i)
          begin
            state_r <= e_hi;
          end
        end
        default:
        begin
          if (link_ready_i)
          begin
            state_r <= e_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load_i && (state_r == e_idle))
    begin
      msg_r <= msg_i;
    end
  end

  always_comb
  begin
    hdr.opcode = msg_r.opcode;
    hdr.pad    = '0;
    hdr.addr   = msg_r.addr;

    link_o.valid = (state_r != e_idle);
    case (state_r)
      e_lo:
      begin
        link_o.flit.last = 1'b0;
        link_o.flit.data = msg_r.data[FLIT_DATA_W-1:0];
      end
      e_hi:
      begin
        link_o.flit.last = 1'b1;
        link_o.flit.data = msg_r.data[DATA_W-1:FLIT_DATA_W];
      end
      default:
      begin
        link_o.flit.last = (msg_r.opcode == e_mem_wr);
        link_o.flit.data = hdr;
      end
    endcase
  end

  // a flit offered to the network must wait unchanged until it is taken
  assert property (@(posedge clk_i) disable iff (rst_i)
    (link_o.valid && !link_ready_i) |=> (link_o.valid && $stable(link_o.flit)))
    else $error("response flit dropped or changed while stalled");

endmodule

/* logic/link_client_ctrl.sv */
`timescale 1ns/1ps

module link_client_ctrl
  import mem_msg_pkg::*;
  (
    input  logic clk_i,
    input  logic rst_i,
    input  logic buf_full_i,
    output logic taken_o,
    output logic dram_cmd_v_o,
    input  logic dram_cmd_yumi_i,
    input  logic dram_resp_v_i,
    output logic dram_resp_ready_o,
    input  logic ser_ready_i,
    output logic ser_load_o
  );

  ctrl_state_e      state_r;
  logic [CNT_W-1:0] cnt_r;
  logic [CNT_W-1:0] cnt_n;
  logic             issue;
  logic             retire;

  // commands only go out while DRAM has room for another one
  assign dram_cmd_v_o = buf_full_i & (state_r == e_run);
  assign issue        = dram_cmd_v_o & dram_cmd_yumi_i;
  assign taken_o      = issue;

  // the serializer accepts a response only when it has nothing left to send
  assign dram_resp_ready_o = ser_ready_i;
  assign retire            = dram_resp_v_i & ser_ready_i;
  assign ser_load_o        = retire;

  always_comb
  begin
    cnt_n = cnt_r;
    if (issue && !retire)
    begin
      cnt_n = cnt_r + CNT_W'(1);
    end
    else if (retire && !issue)
    begin
      cnt_n = cnt_r - CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cnt_r   <= '0;
      state_r <= e_run;
    end
    else
    begin
      cnt_r   <= cnt_n;
      state_r <= (cnt_n == CNT_W'(MAX_OUTSTANDING)) ? e_stall : e_run;
    end
  end

  // DRAM may only consume a command that is offered
  assert property (@(posedge clk_i) disable iff (rst_i)
    dram_cmd_yumi_i |-> dram_cmd_v_o)
    else $error("dram yumi without valid");

  // every response must belong to a command already issued
  assert property (@(posedge clk_i) disable iff (rst_i)
    (dram_resp_v_i && dram_resp_ready_o) |-> (cnt_r != '0))
    else $error("dram response with no command outstanding");

endmodule

/* logic/mem_complex.sv */
`timescale 1ns/1ps

module mem_complex
  import mem_noc_pkg::*;
  import mem_msg_pkg::*;
  (
    input  logic                     clk_i,
    input  logic                     rst_i,

    input  noc_link_s [NUM_COLS-1:0] mem_cmd_link_i,
    output logic      [NUM_COLS-1:0] mem_cmd_ready_o,

    output noc_link_s [NUM_COLS-1:0] mem_resp_link_o,
    input  logic      [NUM_COLS-1:0] mem_resp_ready_i,

    output mem_msg_s  [NUM_COLS-1:0] dram_cmd_o,
    output logic      [NUM_COLS-1:0] dram_cmd_v_o,
    input  logic      [NUM_COLS-1:0] dram_cmd_yumi_i,

    input  mem_msg_s  [NUM_COLS-1:0] dram_resp_i,
    input  logic      [NUM_COLS-1:0] dram_resp_v_i,
    output logic      [NUM_COLS-1:0] dram_resp_ready_o
  );

  for (genvar i = 0; i < NUM_COLS; i++)
  begin : col
    logic buf_full;
    logic taken;
    logic ser_ready;
    logic ser_load;

    cmd_link_deser deser
    (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .link_i     (mem_cmd_link_i[i]),
      .ready_o    (mem_cmd_ready_o[i]),
      .msg_o      (dram_cmd_o[i]),
      .buf_full_o (buf_full),
      .taken_i    (taken)
    );

    link_client_ctrl ctrl
    (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .buf_full_i        (buf_full),
      .taken_o           (taken),
      .dram_cmd_v_o      (dram_cmd_v_o[i]),
      .dram_cmd_yumi_i   (dram_cmd_yumi_i[i]),
      .dram_resp_v_i     (dram_resp_v_i[i]),
      .dram_resp_ready_o (dram_resp_ready_o[i]),
      .ser_ready_i       (ser_ready),
      .ser_load_o        (ser_load)
    );

    resp_link_ser ser
    (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .msg_i        (dram_resp_i[i]),
      .load_i       (ser_load),
      .ready_o      (ser_ready),
      .link_o       (mem_resp_link_o[i]),
      .link_ready_i (mem_resp_ready_i[i])
    );
  end

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
  (
    output logic clk_o
  );

  localparam int HALF_PERIOD = 20; // 40 ns period

  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

/* sim/mem_complex_tb.sv */
`timescale 1ns/1ps

module mem_complex_tb
  import mem_noc_pkg::*;
  import mem_msg_pkg::*;
  ();

  localparam int N_CMDS         = 200;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = N_CMDS * 40;
  localparam int POOL_SIZE      = 16;

  logic                     clk;
  logic                     rst;
  noc_link_s [NUM_COLS-1:0] cmd_link;
  logic      [NUM_COLS-1:0] cmd_ready;
  noc_link_s [NUM_COLS-1:0] resp_link;
  logic      [NUM_COLS-1:0] resp_ready;
  mem_msg_s  [NUM_COLS-1:0] dram_cmd;
  logic      [NUM_COLS-1:0] dram_cmd_v;
  logic      [NUM_COLS-1:0] dram_cmd_yumi;
  mem_msg_s  [NUM_COLS-1:0] dram_resp;
  logic      [NUM_COLS-1:0] dram_resp_v;
  logic      [NUM_COLS-1:0] dram_resp_ready;

  int seed = 969;
  int err_cnt;
  int check_cnt;
  int cyc;
  int timeout_cnt;

  logic [ADDR_W-1:0] addr_pool [POOL_SIZE]; // low 4 bits equal the pool index

  noc_flit_s         flit_q     [NUM_COLS][$]; // command flits still to send
  mem_msg_s          exp_cmd_q  [NUM_COLS][$];
  noc_flit_s         exp_flit_q [NUM_COLS][$];
  logic [DATA_W-1:0] ref_mem    [NUM_COLS][POOL_SIZE];
  int                gen_cnt    [NUM_COLS];
  int                resp_cnt   [NUM_COLS];
  int                outstanding [NUM_COLS];
  logic              cmd_fire   [NUM_COLS];
  logic              resp_fire  [NUM_COLS];

  mem_msg_s          dram_q   [NUM_COLS][$]; // responses waiting in the DRAM model
  int                dram_due [NUM_COLS][$];
  logic [DATA_W-1:0] dram_mem [NUM_COLS][POOL_SIZE];

  tb_clk_gen clk_gen0
  (
    .clk_o (clk)
  );

  mem_complex dut0
  (
    .clk_i             (clk),
    .rst_i             (rst),
    .mem_cmd_link_i    (cmd_link),
    .mem_cmd_ready_o   (cmd_ready),
    .mem_resp_link_o   (resp_link),
    .mem_resp_ready_i  (resp_ready),
    .dram_cmd_o        (dram_cmd),
    .dram_cmd_v_o      (dram_cmd_v),
    .dram_cmd_yumi_i   (dram_cmd_yumi),
    .dram_resp_i       (dram_resp),
    .dram_resp_v_i     (dram_resp_v),
    .dram_resp_ready_o (dram_resp_ready)
  );

  task automatic report_error(input string msg);
    err_cnt++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // builds one random command and the response the network should see for it
  task automatic gen_command(input int c);
    int          k;
    mem_msg_s    cmd;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] hdr;
    k          = $unsigned($random(seed)) % POOL_SIZE;
    lo         = $random(seed);
    hi         = $random(seed);
    cmd.opcode = ($random(seed) & 1) ? e_mem_wr : e_mem_rd;
    cmd.addr   = addr_pool[k];
    cmd.data   = (cmd.opcode == e_mem_wr) ? {hi, lo} : '0;
    hdr        = {cmd.opcode, 2'b00, cmd.addr};
    exp_cmd_q[c].push_back(cmd);
    if (cmd.opcode == e_mem_wr)
    begin
      flit_q[c].push_back({1'b0, hdr});
      flit_q[c].push_back({1'b0, lo});
      flit_q[c].push_back({1'b1, hi});
      ref_mem[c][k] = {hi, lo};
      exp_flit_q[c].push_back({1'b1, hdr}); // write ack is the header alone
    end
    else
    begin
      flit_q[c].push_back({1'b1, hdr});
      exp_flit_q[c].push_back({1'b0, hdr});
      exp_flit_q[c].push_back({1'b0, ref_mem[c][k][31:0]});
      exp_flit_q[c].push_back({1'b1, ref_mem[c][k][63:32]});
    end
    gen_cnt[c]++;
  endtask

  task automatic dram_accept(input int c, input mem_msg_s cmd);
    mem_msg_s rsp;
    rsp = cmd;
    if (cmd.opcode == e_mem_wr)
    begin
      dram_mem[c][cmd.addr[3:0]] = cmd.data;
      rsp.data = '0;
    end
    else
    begin
      rsp.data = dram_mem[c][cmd.addr[3:0]];
    end
    dram_q[c].push_back(rsp);
    dram_due[c].push_back(cyc + 1 + $unsigned($random(seed)) % 8);
  endtask

  // runs one column at a falling edge and decides what moves on the next rising edge
  task automatic step_column(input int c);
    mem_msg_s  exp_cmd;
    noc_flit_s exp_flit;
    if (cmd_fire[c])
    begin
      void'(flit_q[c].pop_front());
      cmd_link[c] = '0;
    end
    if (resp_fire[c])
    begin
      void'(dram_q[c].pop_front());
      void'(dram_due[c].pop_front());
      outstanding[c]--;
    end

    check_cnt++;
    assert (!dram_cmd_v[c] || outstanding[c] < MAX_OUTSTANDING)
      else report_error($sformatf("col %0d offers a dram command with %0d outstanding",
                                  c, outstanding[c]));

    if (!cmd_link[c].valid)
    begin
      if (flit_q[c].size() == 0 && gen_cnt[c] < N_CMDS)
      begin
        gen_command(c);
      end
      if (flit_q[c].size() != 0 && ($random(seed) & 3) != 0)
      begin
        cmd_link[c].valid = 1'b1;
        cmd_link[c].flit  = flit_q[c][0];
      end
    end
    cmd_fire[c] = cmd_link[c].valid & cmd_ready[c];

    dram_cmd_yumi[c] = dram_cmd_v[c] && (($random(seed) & 1) == 0);
    if (dram_cmd_yumi[c])
    begin
      assert (exp_cmd_q[c].size() != 0)
        else report_error($sformatf("col %0d issued a dram command nobody sent", c));
      if (exp_cmd_q[c].size() != 0)
      begin
        exp_cmd = exp_cmd_q[c].pop_front();
        check_cnt++;
        assert (dram_cmd[c] == exp_cmd)
          else report_error($sformatf("col %0d dram command %h, expected %h",
                                      c, dram_cmd[c], exp_cmd));
      end
      dram_accept(c, dram_cmd[c]);
      outstanding[c]++;
    end

    dram_resp_v[c] = 1'b0;
    if (dram_q[c].size() != 0)
    begin
      if (dram_due[c][0] <= cyc)
      begin
        dram_resp_v[c] = 1'b1;
        dram_resp[c]   = dram_q[c][0];
      end
    end
    resp_fire[c] = dram_resp_v[c] & dram_resp_ready[c];

    resp_ready[c] = ($random(seed) & 3) != 0;
    if (resp_link[c].valid && resp_ready[c])
    begin
      assert (exp_flit_q[c].size() != 0)
        else report_error($sformatf("col %0d sent a response flit with no command waiting",
                                    c));
      if (exp_flit_q[c].size() != 0)
      begin
        exp_flit = exp_flit_q[c].pop_front();
        check_cnt++;
        assert (resp_link[c].flit == exp_flit)
          else report_error($sformatf("col %0d response flit %h, expected %h",
                                      c, resp_link[c].flit, exp_flit));
      end
      if (resp_link[c].flit.last)
      begin
        resp_cnt[c]++;
      end
    end
  endtask

  function automatic bit all_done();
    bit done;
    done = 1'b1;
    for (int c = 0; c < NUM_COLS; c++)
    begin
      if (gen_cnt[c] < N_CMDS || flit_q[c].size() != 0 ||
          exp_flit_q[c].size() != 0 || dram_q[c].size() != 0)
      begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  // stimulus and DRAM model change every input on the falling edge
  initial
  begin
    logic [31:0] r;
    rst             = 1'b1;
    cmd_link        = '0;
    resp_ready      = '0;
    dram_cmd_yumi   = '0;
    dram_resp       = '0;
    dram_resp_v     = '0;
    cyc             = 0;
    for (int k = 0; k < POOL_SIZE; k++)
    begin
      r            = $random(seed);
      addr_pool[k] = {r[23:0], 4'(k)};
    end
    for (int c = 0; c < NUM_COLS; c++)
    begin
      gen_cnt[c]     = 0;
      resp_cnt[c]    = 0;
      outstanding[c] = 0;
      cmd_fire[c]    = 1'b0;
      resp_fire[c]   = 1'b0;
      for (int k = 0; k < POOL_SIZE; k++)
      begin
        ref_mem[c][k]  = '0;
        dram_mem[c][k] = '0;
      end
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    forever
    begin
      cyc++;
      for (int c = 0; c < NUM_COLS; c++)
      begin
        step_column(c);
      end
      @(negedge clk);
    end
  end

  initial
  begin
    err_cnt     = 0;
    check_cnt   = 0;
    timeout_cnt = 0;
    @(negedge rst);
    while (!all_done() && timeout_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      timeout_cnt++;
    end
    if (!all_done())
    begin
      $display("run hung: commands still pending after %0d cycles", TIMEOUT_CYCLES);
      err_cnt++;
    end
    else
    begin
      for (int c = 0; c < NUM_COLS; c++)
      begin
        check_cnt++;
        assert (resp_cnt[c] == N_CMDS)
          else report_error($sformatf("col %0d returned %0d responses for %0d commands",
                                      c, resp_cnt[c], N_CMDS));
      end
    end
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
logic/mem_noc_pkg.sv
logic/mem_msg_pkg.sv
logic/cmd_link_deser.sv
logic/resp_link_ser.sv
logic/link_client_ctrl.sv
logic/mem_complex.sv
sim/tb_clk_gen.sv
sim/mem_complex_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory complex testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module mem_complex_tb \
  -Mdir "$BUILD_DIR" -o mem_complex_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/mem_complex_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  exit 1
fi
exit 0
